/* hw/c64_loader_pkg.sv */
`default_nettype none

package c64_loader_pkg;

	// ======================================================================
	// Widths with a meaning
	// ======================================================================

	typedef logic [7:0]  byte_t;
	typedef logic [24:0] mem_addr_t;
	typedef logic [15:0] c64_addr_t;
	typedef logic [24:0] file_ofs_t;

	// Host download stream, wr is a one-cycle strobe
	typedef struct packed {
		logic       download;
		logic [7:0] index;
		file_ofs_t  addr;
		byte_t      data;
		logic       wr;
	} ioctl_t;

	// One byte write toward system memory
	typedef struct packed {
		logic      valid;
		mem_addr_t addr;
		byte_t     data;
	} mem_req_t;

	// Descriptor of one CHIP packet
	typedef struct packed {
		logic [7:0]  bank_type;
		logic [15:0] bank_num;
		c64_addr_t   load_addr;
		logic [15:0] bank_size;
		mem_addr_t   mem_base;
	} crt_bank_t;

	typedef struct packed {
		logic [15:0] cart_id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} cart_hdr_t;

	// ======================================================================
	// File formats
	// ======================================================================

	localparam logic [7:0] IDX_PRG = 8'd4;
	localparam logic [7:0] IDX_CRT = 8'd5;

	localparam mem_addr_t CRT_MEM_BASE = 25'h100000;

	// CRT file header, id is stored high byte first
	localparam file_ofs_t CRT_OFS_ID    = 25'h16;
	localparam file_ofs_t CRT_OFS_EXROM = 25'h18;
	localparam file_ofs_t CRT_OFS_GAME  = 25'h19;
	localparam file_ofs_t CRT_OFS_CHIPS = 25'h40;

	localparam int unsigned CHIP_HDR_LEN    = 16;
	localparam int unsigned BANK_ALIGN_BITS = 13;

	// BASIC zero-page pointers, each pair is low byte then high byte
	localparam c64_addr_t BASIC_TXT_START = 16'h0801;
	localparam c64_addr_t PTR_TXT         = 16'h002B;
	localparam c64_addr_t PTR_VAR         = 16'h002D;
	localparam c64_addr_t PTR_ARY         = 16'h002F;
	localparam c64_addr_t PTR_STR         = 16'h0031;
	localparam c64_addr_t PTR_SAVE_START  = 16'h00AC;
	localparam c64_addr_t PTR_LOAD_END    = 16'h00AE;

	// Number of pointer bytes written after a PRG
	localparam logic [3:0] PTR_WRITE_CNT = 4'd12;

endpackage

`default_nettype wire

/* hw/basic_ptr_injector.sv */
`timescale 1ns/100ps
`default_nettype none

module basic_ptr_injector (
	input  wire                              clk_sys,
	input  wire                              reset_n,
	input  wire                              start_i,
	input  wire c64_loader_pkg::c64_addr_t   load_end_i,
	input  wire                              busy_i,
	output c64_loader_pkg::mem_req_t         req_o,
	output logic                             active_o
);

	logic [3:0]                step_q;
	c64_loader_pkg::c64_addr_t ptr_addr;
	c64_loader_pkg::byte_t     ptr_data;

	// ======================================================================
	// Pointer address and value for the current step
	// ======================================================================

	// Steps 0..7 cover 2B..32, steps 8..11 cover AC..AF
	always_comb begin
		if (step_q < 4'd8) begin
			ptr_addr = c64_loader_pkg::PTR_TXT + c64_loader_pkg::c64_addr_t'(step_q);
		end else begin
			ptr_addr = c64_loader_pkg::PTR_SAVE_START
				+ c64_loader_pkg::c64_addr_t'(step_q - 4'd8);
		end
	end

	always_comb begin
		case (ptr_addr)
			c64_loader_pkg::PTR_TXT:
				ptr_data = c64_loader_pkg::BASIC_TXT_START[7:0];
			c64_loader_pkg::PTR_TXT + 16'd1:
				ptr_data = c64_loader_pkg::BASIC_TXT_START[15:8];
			// Everything else tracks the end of the loaded program
			c64_loader_pkg::PTR_VAR,
			c64_loader_pkg::PTR_ARY,
			c64_loader_pkg::PTR_STR,
			c64_loader_pkg::PTR_LOAD_END:
				ptr_data = load_end_i[7:0];
			c64_loader_pkg::PTR_VAR + 16'd1,
			c64_loader_pkg::PTR_ARY + 16'd1,
			c64_loader_pkg::PTR_STR + 16'd1,
			c64_loader_pkg::PTR_LOAD_END + 16'd1:
				ptr_data = load_end_i[15:8];
			// SAVE_START pair is cleared as after a reset
			default:
				ptr_data = 8'h00;
		endcase
	end

	// ======================================================================
	// Step sequencer
	// ======================================================================

	// busy_i already covers our own request cycle, so one write is in
	// flight at most and the next one follows when the master is idle
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active_o    <= 1'b0;
			step_q      <= '0;
			req_o.valid <= 1'b0;
		end else begin
			req_o.valid <= 1'b0;
			if (start_i) begin
				active_o <= 1'b1;
				step_q   <= '0;
			end else if (active_o && !busy_i) begin
				if (step_q == c64_loader_pkg::PTR_WRITE_CNT) begin
					// Last write acked
					active_o <= 1'b0;
				end else begin
					req_o.valid <= 1'b1;
					req_o.addr  <= c64_loader_pkg::mem_addr_t'(ptr_addr);
					req_o.data  <= ptr_data;
					step_q      <= step_q + 4'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/prg_loader.sv */
`timescale 1ns/100ps
`default_nettype none

module prg_loader (
	input  wire                            clk_sys,
	input  wire                            reset_n,
	input  wire c64_loader_pkg::ioctl_t    host_i,
	input  wire                            busy_i,
	output c64_loader_pkg::mem_req_t       req_o,
	output logic                           inject_busy_o
);

	logic                      prg_dl;
	logic                      prg_wr;
	logic                      prg_dl_q;
	logic                      inj_start;
	logic                      inj_active;
	c64_loader_pkg::c64_addr_t run_addr_q;
	c64_loader_pkg::mem_req_t  pay_req_q;
	c64_loader_pkg::mem_req_t  inj_req;

	assign prg_dl = host_i.download && (host_i.index == c64_loader_pkg::IDX_PRG);
	assign prg_wr = prg_dl && host_i.wr;

	// Falling edge of a PRG download kicks off the pointer writes
	assign inj_start = prg_dl_q && !host_i.download;

	// ======================================================================
	// Header and payload
	// ======================================================================

	// run_addr_q starts at the load address and ends up at the load end
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			prg_dl_q        <= 1'b0;
			pay_req_q.valid <= 1'b0;
		end else begin
			prg_dl_q        <= prg_dl;
			pay_req_q.valid <= 1'b0;
			if (prg_wr) begin
				if (host_i.addr == c64_loader_pkg::file_ofs_t'(0)) begin
					run_addr_q[7:0] <= host_i.data;
				end else if (host_i.addr == c64_loader_pkg::file_ofs_t'(1)) begin
					run_addr_q[15:8] <= host_i.data;
				end else begin
					pay_req_q.valid <= 1'b1;
					pay_req_q.addr  <= c64_loader_pkg::mem_addr_t'(run_addr_q);
					pay_req_q.data  <= host_i.data;
					run_addr_q      <= run_addr_q + 16'd1;
				end
			end
		end
	end

	// ======================================================================
	// BASIC pointer injection
	// ======================================================================

	basic_ptr_injector basic_ptr_injector_i (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.start_i    (inj_start),
		.load_end_i (run_addr_q),
		.busy_i     (busy_i),
		.req_o      (inj_req),
		.active_o   (inj_active)
	);

	// Payload and injection never overlap
	assign req_o = inj_req.valid ? inj_req : pay_req_q;

	assign inject_busy_o = inj_active | inj_start;

endmodule

`default_nettype wire

/* hw/crt_parser.sv */
`timescale 1ns/100ps
`default_nettype none

module crt_parser (
	input  wire                            clk_sys,
	input  wire                            reset_n,
	input  wire c64_loader_pkg::ioctl_t    host_i,
	input  wire                            busy_i,
	output c64_loader_pkg::mem_req_t       req_o,
	output c64_loader_pkg::cart_hdr_t      cart_hdr_o,
	output c64_loader_pkg::crt_bank_t      bank_o,
	output logic                           bank_wr_o,
	output logic                           cart_attached_o
);

	logic                      crt_dl;
	logic                      crt_wr;
	logic                      crt_dl_q;
	logic [3:0]                hdr_cnt_q;
	logic [31:0]               blk_len_q;
	c64_loader_pkg::mem_addr_t mem_addr_q;
	c64_loader_pkg::mem_addr_t mem_aligned;

	assign crt_dl = host_i.download && (host_i.index == c64_loader_pkg::IDX_CRT);

	// Host only strobes while wait is low, which already covers busy_i
	assign crt_wr = crt_dl && host_i.wr && !busy_i;

	// Round up to the next bank boundary, aligned addresses stay put
	always_comb begin
		mem_aligned = mem_addr_q
			+ c64_loader_pkg::mem_addr_t'((1 << c64_loader_pkg::BANK_ALIGN_BITS) - 1);
		mem_aligned[c64_loader_pkg::BANK_ALIGN_BITS-1:0] = '0;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			crt_dl_q        <= 1'b0;
			hdr_cnt_q       <= '0;
			blk_len_q       <= '0;
			req_o.valid     <= 1'b0;
			bank_wr_o       <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			crt_dl_q    <= crt_dl;
			req_o.valid <= 1'b0;
			bank_wr_o   <= 1'b0;

			// Detached while a new image streams in
			if (crt_dl && !crt_dl_q)
				cart_attached_o <= 1'b0;
			if (!crt_dl && crt_dl_q)
				cart_attached_o <= 1'b1;

			if (crt_wr) begin
				if (host_i.addr == c64_loader_pkg::file_ofs_t'(0)) begin
					mem_addr_q <= c64_loader_pkg::CRT_MEM_BASE;
					blk_len_q  <= '0;
					hdr_cnt_q  <= '0;
				end

				// ==========================================================
				// File header
				// ==========================================================
				if (host_i.addr == c64_loader_pkg::CRT_OFS_ID)
					cart_hdr_o.cart_id[15:8] <= host_i.data;
				if (host_i.addr == c64_loader_pkg::CRT_OFS_ID + 25'd1)
					cart_hdr_o.cart_id[7:0] <= host_i.data;
				if (host_i.addr == c64_loader_pkg::CRT_OFS_EXROM)
					cart_hdr_o.exrom <= host_i.data;
				if (host_i.addr == c64_loader_pkg::CRT_OFS_GAME)
					cart_hdr_o.game <= host_i.data;

				// ==========================================================
				// CHIP packets
				// ==========================================================
				if (host_i.addr >= c64_loader_pkg::CRT_OFS_CHIPS) begin
					if (blk_len_q == '0 && hdr_cnt_q == '0) begin
						// First byte of a new packet
						hdr_cnt_q  <= 4'd1;
						mem_addr_q <= mem_aligned;
					end else if (hdr_cnt_q != '0) begin
						// Wraps to zero after byte 15, data follows
						hdr_cnt_q <= hdr_cnt_q + 4'd1;
						case (hdr_cnt_q)
							4'd4:  blk_len_q[31:24] <= host_i.data;
							4'd5:  blk_len_q[23:16] <= host_i.data;
							4'd6:  blk_len_q[15:8]  <= host_i.data;
							4'd7:  blk_len_q[7:0]   <= host_i.data;
							4'd8:  blk_len_q <= blk_len_q - 32'(c64_loader_pkg::CHIP_HDR_LEN);
							4'd9:  bank_o.bank_type       <= host_i.data;
							4'd10: bank_o.bank_num[15:8]  <= host_i.data;
							4'd11: bank_o.bank_num[7:0]   <= host_i.data;
							4'd12: bank_o.load_addr[15:8] <= host_i.data;
							4'd13: bank_o.load_addr[7:0]  <= host_i.data;
							4'd14: bank_o.bank_size[15:8] <= host_i.data;
							4'd15: begin
								bank_o.bank_size[7:0] <= host_i.data;
								bank_o.mem_base       <= mem_addr_q;
								bank_wr_o             <= 1'b1;
							end
							default: ;
						endcase
					end else begin
						// Bank data
						blk_len_q   <= blk_len_q - 32'd1;
						req_o.valid <= 1'b1;
						req_o.addr  <= mem_addr_q;
						req_o.data  <= host_i.data;
						mem_addr_q  <= mem_addr_q + 25'd1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/load_write_master.sv */
`timescale 1ns/100ps
`default_nettype none

module load_write_master (
	input  wire                            clk_sys,
	input  wire                            reset_n,
	input  wire c64_loader_pkg::mem_req_t  prg_req_i,
	input  wire c64_loader_pkg::mem_req_t  crt_req_i,
	output logic                           busy_o,
	output logic                           wb_cyc_o,
	output logic                           wb_stb_o,
	output logic                           wb_we_o,
	output c64_loader_pkg::mem_addr_t      wb_adr_o,
	output c64_loader_pkg::byte_t          wb_dat_o,
	input  wire                            wb_ack_i
);

	c64_loader_pkg::mem_req_t req_in;
	c64_loader_pkg::mem_req_t hold_q;

	// Requesters are mutually exclusive
	assign req_in = prg_req_i.valid ? prg_req_i : crt_req_i;

	// ======================================================================
	// One-entry holding register
	// ======================================================================

	// Entry stays until the slave acks, so address and data are stable
	// for the whole bus cycle
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			hold_q.valid <= 1'b0;
		end else if (hold_q.valid) begin
			if (wb_ack_i)
				hold_q.valid <= 1'b0;
		end else if (req_in.valid) begin
			hold_q <= req_in;
		end
	end

	// Busy from the latch cycle through the ack cycle
	assign busy_o = hold_q.valid | req_in.valid;

	// ======================================================================
	// Wishbone classic write
	// ======================================================================

	// Write only master
	assign wb_cyc_o = hold_q.valid;
	assign wb_stb_o = hold_q.valid;
	assign wb_we_o  = hold_q.valid;
	assign wb_adr_o = hold_q.addr;
	assign wb_dat_o = hold_q.data;

endmodule

`default_nettype wire

/* hw/c64_loader_top.sv */
`timescale 1ns/100ps
`default_nettype none

module c64_loader_top (
	input  wire                            clk_sys,
	input  wire                            reset_n,
	input  wire c64_loader_pkg::ioctl_t    host_i,
	output logic                           wait_o,
	output logic                           wb_cyc_o,
	output logic                           wb_stb_o,
	output logic                           wb_we_o,
	output c64_loader_pkg::mem_addr_t      wb_adr_o,
	output c64_loader_pkg::byte_t          wb_dat_o,
	input  wire                            wb_ack_i,
	output c64_loader_pkg::cart_hdr_t      cart_hdr_o,
	output c64_loader_pkg::crt_bank_t      bank_o,
	output logic                           bank_wr_o,
	output logic                           cart_attached_o
);

	c64_loader_pkg::mem_req_t prg_req;
	c64_loader_pkg::mem_req_t crt_req;
	logic                     busy;
	logic                     inject_busy;

	prg_loader prg_loader_i (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.host_i        (host_i),
		.busy_i        (busy),
		.req_o         (prg_req),
		.inject_busy_o (inject_busy)
	);

	crt_parser crt_parser_i (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.host_i          (host_i),
		.busy_i          (busy),
		.req_o           (crt_req),
		.cart_hdr_o      (cart_hdr_o),
		.bank_o          (bank_o),
		.bank_wr_o       (bank_wr_o),
		.cart_attached_o (cart_attached_o)
	);

	load_write_master load_write_master_i (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.prg_req_i (prg_req),
		.crt_req_i (crt_req),
		.busy_o    (busy),
		.wb_cyc_o  (wb_cyc_o),
		.wb_stb_o  (wb_stb_o),
		.wb_we_o   (wb_we_o),
		.wb_adr_o  (wb_adr_o),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_i  (wb_ack_i)
	);

	// Host holds off during a bus cycle and during pointer injection
	assign wait_o = busy | inject_busy;

endmodule

`default_nettype wire

/* tb/c64_loader_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module c64_loader_sva (
	input wire                            clk_sys,
	input wire                            reset_n,
	input wire c64_loader_pkg::mem_req_t  prg_req_i,
	input wire c64_loader_pkg::mem_req_t  crt_req_i,
	input wire                            busy_i,
	input wire                            cyc_i,
	input wire                            stb_i,
	input wire c64_loader_pkg::mem_addr_t adr_i,
	input wire c64_loader_pkg::byte_t     dat_i,
	input wire                            ack_i
);

	int unsigned fail_cnt = 0;

	// ======================================================================
	// Wishbone classic write protocol
	// ======================================================================

	a_stb_in_cyc: assert property (@(posedge clk_sys) disable iff (!reset_n)
		stb_i |-> cyc_i)
		else begin
			fail_cnt++;
			$error("wb_stb_o high without wb_cyc_o");
		end

	// Address and data hold until the slave acks
	a_stable_until_ack: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(stb_i && !ack_i) |=> (stb_i && $stable(adr_i) && $stable(dat_i)))
		else begin
			fail_cnt++;
			$error("wb_adr_o or wb_dat_o changed before ack");
		end

	a_busy_during_stb: assert property (@(posedge clk_sys) disable iff (!reset_n)
		stb_i |-> busy_i)
		else begin
			fail_cnt++;
			$error("busy_o low during a bus cycle");
		end

	// A requester only fires when no entry is held
	a_no_req_while_busy: assert property (@(posedge clk_sys) disable iff (!reset_n)
		(prg_req_i.valid || crt_req_i.valid) |-> !cyc_i)
		else begin
			fail_cnt++;
			$error("write request arrived while the master was busy");
		end

endmodule

bind load_write_master c64_loader_sva c64_loader_sva_i (
	.clk_sys   (clk_sys),
	.reset_n   (reset_n),
	.prg_req_i (prg_req_i),
	.crt_req_i (crt_req_i),
	.busy_i    (busy_o),
	.cyc_i     (wb_cyc_o),
	.stb_i     (wb_stb_o),
	.adr_i     (wb_adr_o),
	.dat_i     (wb_dat_o),
	.ack_i     (wb_ack_i)
);

`default_nettype wire

/* tb/tb_c64_loader.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_c64_loader;

	localparam int HOST_TIMEOUT = 200;
	localparam int DONE_TIMEOUT = 5000;

	typedef struct packed {
		c64_loader_pkg::mem_addr_t addr;
		c64_loader_pkg::byte_t     data;
	} wr_entry_t;

	logic                      clk_sys = 1'b0;
	logic                      reset_n;
	c64_loader_pkg::ioctl_t    host;
	logic                      dut_wait;
	logic                      wb_cyc;
	logic                      wb_stb;
	logic                      wb_we;
	c64_loader_pkg::mem_addr_t wb_adr;
	c64_loader_pkg::byte_t     wb_dat;
	logic                      wb_ack = 1'b0;
	c64_loader_pkg::cart_hdr_t cart_hdr;
	c64_loader_pkg::crt_bank_t bank;
	logic                      bank_wr;
	logic                      cart_attached;

	c64_loader_pkg::byte_t     file_q[$];
	wr_entry_t                 exp_log[$];
	wr_entry_t                 got_log[$];
	c64_loader_pkg::crt_bank_t exp_banks[$];
	c64_loader_pkg::crt_bank_t got_banks[$];
	c64_loader_pkg::cart_hdr_t exp_hdr;
	c64_loader_pkg::byte_t     mem[c64_loader_pkg::mem_addr_t];
	int unsigned               ack_delay[512];
	int                        ack_cnt = 0;
	int                        delay_left = 0;
	logic                      armed = 1'b0;
	logic                      check_req = 1'b0;
	logic                      check_crt = 1'b0;
	int                        errors = 0;
	int                        tests_run = 0;
	int                        tests_failed = 0;

	always #10 clk_sys = ~clk_sys;

	c64_loader_top c64_loader_top_i (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.host_i          (host),
		.wait_o          (dut_wait),
		.wb_cyc_o        (wb_cyc),
		.wb_stb_o        (wb_stb),
		.wb_we_o         (wb_we),
		.wb_adr_o        (wb_adr),
		.wb_dat_o        (wb_dat),
		.wb_ack_i        (wb_ack),
		.cart_hdr_o      (cart_hdr),
		.bank_o          (bank),
		.bank_wr_o       (bank_wr),
		.cart_attached_o (cart_attached)
	);

	// ======================================================================
	// Wishbone slave with random wait states, and bank monitor
	// ======================================================================

	always @(posedge clk_sys) begin
		wr_entry_t ent;
		if (!reset_n) begin
			wb_ack <= 1'b0;
			armed  <= 1'b0;
		end else if (wb_ack) begin
			// Master sees ack at this edge
			ent.addr = wb_adr;
			ent.data = wb_dat;
			got_log.push_back(ent);
			mem[wb_adr] = wb_dat;
			wb_ack <= 1'b0;
			armed  <= 1'b0;
		end else if (wb_stb) begin
			if (!armed) begin
				armed      <= 1'b1;
				delay_left <= int'(ack_delay[ack_cnt % 512]);
				ack_cnt    <= ack_cnt + 1;
			end else if (delay_left == 0) begin
				wb_ack <= 1'b1;
			end else begin
				delay_left <= delay_left - 1;
			end
		end
	end

	// Every bus cycle is a write and holds the host off
	always @(posedge clk_sys) begin
		if (reset_n && wb_stb) begin
			compare_bit("wb_we_o", wb_we, 1'b1);
			compare_bit("wait_o during a bus cycle", dut_wait, 1'b1);
		end
	end

	always @(posedge clk_sys) begin
		if (reset_n && bank_wr)
			got_banks.push_back(bank);
	end

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task automatic compare_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_count(input string what, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic compare_addr(input string what, input c64_loader_pkg::mem_addr_t got,
		input c64_loader_pkg::mem_addr_t exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_byte(input string what, input c64_loader_pkg::byte_t got,
		input c64_loader_pkg::byte_t exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_hdr(input c64_loader_pkg::cart_hdr_t got,
		input c64_loader_pkg::cart_hdr_t exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: cartridge header is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic compare_bank(input int idx, input c64_loader_pkg::crt_bank_t got,
		input c64_loader_pkg::crt_bank_t exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: bank %0d descriptor is %h, expected %h",
				$time, idx, got, exp);
		end
	endtask

	// Runs on the falling edge, when queues and DUT outputs are settled
	always @(negedge clk_sys) begin
		int i;
		int n;
		c64_loader_pkg::mem_addr_t a;
		if (check_req) begin
			compare_count("write count", got_log.size(), exp_log.size());
			n = (got_log.size() < exp_log.size()) ? got_log.size() : exp_log.size();
			for (i = 0; i < n; i++) begin
				compare_addr($sformatf("write %0d address", i), got_log[i].addr,
					exp_log[i].addr);
				compare_byte($sformatf("write %0d data", i), got_log[i].data,
					exp_log[i].data);
			end
			for (i = 0; i < exp_log.size(); i++) begin
				a = exp_log[i].addr;
				if (!mem.exists(a)) begin
					errors++;
					$display("Error at %0t: nothing was written at address %h", $time, a);
				end else begin
					compare_byte($sformatf("memory at %h", a), mem[a], exp_log[i].data);
				end
			end
			compare_count("bank descriptors", got_banks.size(), exp_banks.size());
			n = (got_banks.size() < exp_banks.size()) ? got_banks.size() : exp_banks.size();
			for (i = 0; i < n; i++)
				compare_bank(i, got_banks[i], exp_banks[i]);
			if (check_crt) begin
				compare_hdr(cart_hdr, exp_hdr);
				compare_bit("cart_attached_o", cart_attached, 1'b1);
			end
			check_req = 1'b0;
		end
	end

	// ======================================================================
	// Reference model
	// ======================================================================

	function automatic void expect_write(input c64_loader_pkg::mem_addr_t a,
		input c64_loader_pkg::byte_t d);
		wr_entry_t ent;
		ent.addr = a;
		ent.data = d;
		exp_log.push_back(ent);
	endfunction

	function automatic void build_expected(input logic is_crt);
		c64_loader_pkg::c64_addr_t load;
		c64_loader_pkg::c64_addr_t load_end;
		c64_loader_pkg::mem_addr_t base;
		c64_loader_pkg::mem_addr_t next;
		c64_loader_pkg::crt_bank_t bk;
		int ofs;
		int plen;
		int dlen;
		exp_log.delete();
		exp_banks.delete();
		if (!is_crt) begin
			load = {file_q[1], file_q[0]};
			for (int i = 2; i < file_q.size(); i++)
				expect_write(25'(16'(load + 16'(i - 2))), file_q[i]);
			load_end = load + 16'(file_q.size() - 2);
			// Pointer bytes in ascending address order
			expect_write(25'h2B, 8'h01);
			expect_write(25'h2C, 8'h08);
			expect_write(25'h2D, load_end[7:0]);
			expect_write(25'h2E, load_end[15:8]);
			expect_write(25'h2F, load_end[7:0]);
			expect_write(25'h30, load_end[15:8]);
			expect_write(25'h31, load_end[7:0]);
			expect_write(25'h32, load_end[15:8]);
			expect_write(25'hAC, 8'h00);
			expect_write(25'hAD, 8'h00);
			expect_write(25'hAE, load_end[7:0]);
			expect_write(25'hAF, load_end[15:8]);
		end else begin
			exp_hdr.cart_id = {file_q['h16], file_q['h17]};
			exp_hdr.exrom   = file_q['h18];
			exp_hdr.game    = file_q['h19];
			next = 25'h100000;
			ofs  = 'h40;
			while (ofs < file_q.size()) begin
				plen = int'({file_q[ofs+4], file_q[ofs+5], file_q[ofs+6], file_q[ofs+7]});
				dlen = plen - 16;
				// Each bank starts on an 8 KB boundary
				base = (next + 25'h1FFF) & ~25'h1FFF;
				bk.bank_type = file_q[ofs+9];
				bk.bank_num  = {file_q[ofs+10], file_q[ofs+11]};
				bk.load_addr = {file_q[ofs+12], file_q[ofs+13]};
				bk.bank_size = {file_q[ofs+14], file_q[ofs+15]};
				bk.mem_base  = base;
				exp_banks.push_back(bk);
				for (int i = 0; i < dlen; i++)
					expect_write(base + 25'(i), file_q[ofs+16+i]);
				next = base + 25'(dlen);
				ofs  = ofs + plen;
			end
		end
	endfunction

	// ======================================================================
	// File builders and host driver
	// ======================================================================

	function automatic void make_prg(input c64_loader_pkg::c64_addr_t load, input int n);
		file_q.delete();
		file_q.push_back(load[7:0]);
		file_q.push_back(load[15:8]);
		for (int i = 0; i < n; i++)
			file_q.push_back(8'($urandom));
	endfunction

	function automatic void add_chip(input logic [7:0] typ, input logic [15:0] num,
		input logic [15:0] load, input int dlen);
		logic [31:0] plen;
		plen = 32'(dlen + 16);
		// "CHIP" signature
		file_q.push_back(8'h43);
		file_q.push_back(8'h48);
		file_q.push_back(8'h49);
		file_q.push_back(8'h50);
		for (int i = 3; i >= 0; i--)
			file_q.push_back(plen[i*8 +: 8]);
		file_q.push_back(8'h00);
		file_q.push_back(typ);
		file_q.push_back(num[15:8]);
		file_q.push_back(num[7:0]);
		file_q.push_back(load[15:8]);
		file_q.push_back(load[7:0]);
		file_q.push_back(8'(dlen >> 8));
		file_q.push_back(8'(dlen));
		for (int i = 0; i < dlen; i++)
			file_q.push_back(8'($urandom));
	endfunction

	function automatic void make_crt();
		file_q.delete();
		for (int i = 0; i < 'h40; i++)
			file_q.push_back(8'h00);
		file_q['h16] = 8'($urandom);
		file_q['h17] = 8'($urandom);
		file_q['h18] = 8'($urandom % 2);
		file_q['h19] = 8'($urandom % 2);
		add_chip(8'h00, 16'd0, 16'h8000, 1 + int'($urandom % 24));
		add_chip(8'h00, 16'd1, 16'hA000, 1 + int'($urandom % 24));
	endfunction

	task automatic abort_run(input string what);
		errors++;
		$display("Timeout while waiting for %s", what);
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic send_byte(input c64_loader_pkg::file_ofs_t ofs,
		input c64_loader_pkg::byte_t val);
		int cnt;
		cnt = 0;
		@(negedge clk_sys);
		while (dut_wait && cnt < HOST_TIMEOUT) begin
			@(negedge clk_sys);
			cnt++;
		end
		if (dut_wait)
			abort_run("wait_o to fall before a host byte");
		@(posedge clk_sys);
		host.addr <= ofs;
		host.data <= val;
		host.wr   <= 1'b1;
		@(posedge clk_sys);
		host.wr   <= 1'b0;
	endtask

	task automatic send_file(input logic [7:0] idx);
		@(posedge clk_sys);
		host.download <= 1'b1;
		host.index    <= idx;
		for (int i = 0; i < file_q.size(); i++)
			send_byte(c64_loader_pkg::file_ofs_t'(i), file_q[i]);
		@(posedge clk_sys);
		host.download <= 1'b0;
	endtask

	task automatic wait_writes_done();
		int cnt;
		cnt = 0;
		@(negedge clk_sys);
		while ((dut_wait || got_log.size() < exp_log.size()) && cnt < DONE_TIMEOUT) begin
			@(negedge clk_sys);
			cnt++;
		end
		if (dut_wait || got_log.size() < exp_log.size())
			abort_run("all memory writes to complete");
		// Quiet window to catch stray writes
		repeat (8) @(posedge clk_sys);
	endtask

	task automatic run_checks(input logic is_crt);
		int cnt;
		cnt = 0;
		check_crt = is_crt;
		check_req = 1'b1;
		while (check_req && cnt < 10) begin
			@(posedge clk_sys);
			cnt++;
		end
		if (check_req)
			abort_run("the checker");
	endtask

	task automatic start_test();
		got_log.delete();
		got_banks.delete();
		mem.delete();
	endtask

	task automatic finish_test(input string name, input int err_start);
		tests_run++;
		if (errors != err_start) begin
			tests_failed++;
			$display("Test %0d %s: failed with %0d errors", tests_run, name,
				errors - err_start);
		end else begin
			$display("Test %0d %s: ok", tests_run, name);
		end
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		c64_loader_pkg::c64_addr_t load;
		int n;
		int err_start;
		int sva_fails;
		reset_n = 1'b0;
		host    = '0;
		void'($urandom(32'h2587));
		for (int i = 0; i < 512; i++)
			ack_delay[i] = $urandom % 6;
		repeat (3) @(posedge clk_sys);
		reset_n <= 1'b1;

		err_start = errors;
		@(negedge clk_sys);
		compare_bit("wb_cyc_o", wb_cyc, 1'b0);
		compare_bit("wb_stb_o", wb_stb, 1'b0);
		compare_bit("wb_we_o", wb_we, 1'b0);
		compare_bit("wait_o", dut_wait, 1'b0);
		compare_bit("bank_wr_o", bank_wr, 1'b0);
		compare_bit("cart_attached_o", cart_attached, 1'b0);
		finish_test("reset state", err_start);

		for (int t = 0; t < 2; t++) begin
			err_start = errors;
			start_test();
			load = 16'h0801 + 16'($urandom % 32'hB000);
			n    = 1 + int'($urandom % 48);
			make_prg(load, n);
			build_expected(1'b0);
			send_file(c64_loader_pkg::IDX_PRG);
			wait_writes_done();
			run_checks(1'b0);
			finish_test($sformatf("PRG of %0d bytes at %h", n, load), err_start);
		end

		err_start = errors;
		start_test();
		make_crt();
		build_expected(1'b1);
		send_file(c64_loader_pkg::IDX_CRT);
		wait_writes_done();
		run_checks(1'b1);
		finish_test("CRT with two CHIP packets", err_start);

		sva_fails = int'(c64_loader_top_i.load_write_master_i.c64_loader_sva_i.fail_cnt);
		if (sva_fails != 0) begin
			errors += sva_fails;
			$display("Bound assertions failed %0d times", sva_fails);
		end

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* c64_loader_top.f */
hw/c64_loader_pkg.sv
hw/basic_ptr_injector.sv
hw/prg_loader.sv
hw/crt_parser.sv
hw/load_write_master.sv
hw/c64_loader_top.sv
tb/c64_loader_sva.sv
tb/tb_c64_loader.sv

/* Bender.yml */
package:
  name: c64_loader

sources:
  # RTL, package first
  - hw/c64_loader_pkg.sv
  - hw/basic_ptr_injector.sv
  - hw/prg_loader.sv
  - hw/crt_parser.sv
  - hw/load_write_master.sv
  - hw/c64_loader_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - tb/c64_loader_sva.sv
      - tb/tb_c64_loader.sv
